// File: include/fpu_conv_settings.svh
`ifndef FPU_CONV_SETTINGS_SVH
`define FPU_CONV_SETTINGS_SVH

// single precision word layout
`define FPU_CONV_WORD_W 32
`define FPU_CONV_EXP_W 8
`define FPU_CONV_FRAC_W 23
`define FPU_CONV_BIAS 127

// integer saturation limits
`define FPU_CONV_INT_MAX 32'h7fffffff
`define FPU_CONV_INT_MIN 32'h80000000

`endif

// File: hw/fpu_conv_pkg.sv
`default_nettype none

`include "fpu_conv_settings.svh"

package fpu_conv_pkg;

   typedef logic [`FPU_CONV_WORD_W-1:0] word_t;   // integer or float bit pattern
   typedef logic [`FPU_CONV_EXP_W-1:0]  exp_t;
   typedef logic [`FPU_CONV_FRAC_W-1:0] frac_t;

   typedef enum logic {
      op_i2f = 1'b0,
      op_f2i = 1'b1
   } conv_op_t;

   // invalid, inexact, inf, snan, qnan, zero from msb down
   typedef logic [5:0] conv_flags_t;

   typedef logic client_id_t;

   typedef enum logic [1:0] {
      cl_idle,
      cl_wait,
      cl_busy,
      cl_ack
   } client_state_t;

endpackage

`default_nettype wire

// File: hw/fpu_intfloat_conv_except.sv
`default_nettype none
`timescale 1ns/100ps

module fpu_intfloat_conv_except (
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire fpu_conv_pkg::word_t opa,
   output logic                     inf,
   output logic                     qnan,
   output logic                     snan,
   output logic                     zero,
   output logic                     denorm
);
   import fpu_conv_pkg::*;

   exp_t  exp_f;
   frac_t frac_f;
   logic  exp_ones;
   logic  exp_zero;
   logic  frac_zero;
   logic  quiet;
   logic  sig_nz;     // payload below the quiet bit

   assign exp_f  = opa[$bits(word_t)-2 -: $bits(exp_t)];
   assign frac_f = opa[$bits(frac_t)-1:0];

   // stage one
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         exp_ones  <= 1'b0;
         exp_zero  <= 1'b0;
         frac_zero <= 1'b0;
         quiet     <= 1'b0;
         sig_nz    <= 1'b0;
      end else begin
         exp_ones  <= &exp_f;
         exp_zero  <= ~|exp_f;
         frac_zero <= ~|frac_f;
         quiet     <= frac_f[$bits(frac_t)-1];
         sig_nz    <= |frac_f[$bits(frac_t)-2:0];
      end
   end

   // stage two, registered class outputs
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         inf    <= 1'b0;
         qnan   <= 1'b0;
         snan   <= 1'b0;
         zero   <= 1'b0;
         denorm <= 1'b0;
      end else begin
         inf    <= exp_ones & frac_zero;
         qnan   <= exp_ones & quiet;
         snan   <= exp_ones & ~quiet & sig_nz;   // quiet bit clear, rest of payload set
         zero   <= exp_zero & frac_zero;
         denorm <= exp_zero & ~frac_zero;
      end
   end

endmodule

`default_nettype wire

// File: hw/fpu_int2float.sv
`default_nettype none
`timescale 1ns/100ps

`include "fpu_conv_settings.svh"

module fpu_int2float (
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire fpu_conv_pkg::word_t opa,
   output fpu_conv_pkg::word_t      res,
   output logic                     inexact
);
   import fpu_conv_pkg::*;

   localparam int unsigned GUARD = `FPU_CONV_WORD_W - `FPU_CONV_FRAC_W - 2;

   word_t                       mag;
   logic [4:0]                  pos;
   logic                        s1_sign;
   word_t                       s1_mag;
   logic [4:0]                  s1_pos;
   word_t                       norm;
   logic [`FPU_CONV_FRAC_W:0]   sig;
   logic                        guard;
   logic                        sticky;
   logic                        round_up;
   logic [`FPU_CONV_FRAC_W+1:0] sig_rnd;
   exp_t                        exp_b;
   frac_t                       frac;

   assign mag = opa[`FPU_CONV_WORD_W-1] ? ~opa + word_t'(1) : opa;   // -2^31 stays 2^31

   // leading one search
   always_comb begin
      pos = '0;
      for (int i = 0; i < `FPU_CONV_WORD_W; i++) begin
         if (mag[i])
            pos = 5'(i);
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         s1_sign <= 1'b0;
         s1_mag  <= '0;
         s1_pos  <= '0;
      end else begin
         s1_sign <= opa[`FPU_CONV_WORD_W-1];
         s1_mag  <= mag;
         s1_pos  <= pos;
      end
   end

   assign norm     = s1_mag << (5'd31 - s1_pos);   // leading one to msb
   assign sig      = norm[`FPU_CONV_WORD_W-1 -: `FPU_CONV_FRAC_W+1];
   assign guard    = norm[GUARD];
   assign sticky   = |norm[GUARD-1:0];
   assign round_up = guard & (sticky | sig[0]);   // nearest, ties to even
   assign sig_rnd  = {1'b0, sig} + (`FPU_CONV_FRAC_W+2)'(round_up);

   // a carry out leaves an all zero fraction, only the exponent moves
   assign exp_b = exp_t'(`FPU_CONV_BIAS) + exp_t'(s1_pos) + exp_t'(sig_rnd[`FPU_CONV_FRAC_W+1]);
   assign frac  = sig_rnd[`FPU_CONV_FRAC_W-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         res     <= '0;
         inexact <= 1'b0;
      end else begin
         res     <= (s1_mag == '0) ? '0 : {s1_sign, exp_b, frac};
         inexact <= guard | sticky;
      end
   end

endmodule

`default_nettype wire

// File: hw/fpu_float2int.sv
`default_nettype none
`timescale 1ns/100ps

`include "fpu_conv_settings.svh"

module fpu_float2int (
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire fpu_conv_pkg::word_t opa,
   output fpu_conv_pkg::word_t      res,
   output logic                     inexact,
   output logic                     ovf
);
   import fpu_conv_pkg::*;

   localparam logic signed [`FPU_CONV_EXP_W:0] BIAS_S = `FPU_CONV_BIAS;

   exp_t                                          exp_b;
   frac_t                                         frac;
   logic                                          s1_sign;
   logic signed [`FPU_CONV_EXP_W:0]               s1_uexp;
   logic [`FPU_CONV_FRAC_W:0]                     s1_sig;
   logic [`FPU_CONV_WORD_W+`FPU_CONV_FRAC_W-1:0]  ext;
   word_t                                         mag;
   logic                                          is_min;

   assign exp_b = opa[`FPU_CONV_WORD_W-2 -: `FPU_CONV_EXP_W];
   assign frac  = opa[`FPU_CONV_FRAC_W-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         s1_sign <= 1'b0;
         s1_uexp <= '0;
         s1_sig  <= '0;
      end else begin
         s1_sign <= opa[`FPU_CONV_WORD_W-1];
         s1_uexp <= $signed({1'b0, exp_b}) - BIAS_S;
         s1_sig  <= {|exp_b, frac};   // hidden bit only for normal numbers
      end
   end

   // integer part ends up in the top word of ext
   assign ext = {{(`FPU_CONV_WORD_W-1){1'b0}}, s1_sig} << s1_uexp[4:0];
   assign mag = ext[`FPU_CONV_WORD_W+`FPU_CONV_FRAC_W-1 -: `FPU_CONV_WORD_W];

   assign is_min = s1_sign && (s1_uexp == 9'sd31) && (s1_sig == {1'b1, {`FPU_CONV_FRAC_W{1'b0}}});

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         res     <= '0;
         inexact <= 1'b0;
         ovf     <= 1'b0;
      end else if (s1_uexp >= 9'sd31) begin
         res     <= s1_sign ? word_t'(`FPU_CONV_INT_MIN) : word_t'(`FPU_CONV_INT_MAX);
         inexact <= 1'b0;
         ovf     <= ~is_min;   // -2^31 itself fits
      end else if (s1_uexp < 9'sd0) begin
         res     <= '0;
         inexact <= |s1_sig;
         ovf     <= 1'b0;
      end else begin
         res     <= s1_sign ? ~mag + word_t'(1) : mag;
         inexact <= |ext[`FPU_CONV_FRAC_W-1:0];
         ovf     <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: hw/fpu_conv_core.sv
`default_nettype none
`timescale 1ns/100ps

`include "fpu_conv_settings.svh"

module fpu_conv_core (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     issue_valid,
   input  wire fpu_conv_pkg::conv_op_t   issue_op,
   input  wire fpu_conv_pkg::word_t      issue_opa,
   input  wire fpu_conv_pkg::client_id_t issue_id,
   output logic                          done_valid,
   output fpu_conv_pkg::client_id_t      done_id,
   output fpu_conv_pkg::word_t           done_res,
   output fpu_conv_pkg::conv_flags_t     done_flags
);
   import fpu_conv_pkg::*;

   logic       v0, v1, v2;
   conv_op_t   op0, op1, op2;
   client_id_t id0, id1, id2;
   word_t      opa0;
   logic       cls_inf, cls_qnan, cls_snan, cls_zero, cls_dn;
   word_t      i2f_res, f2i_res;
   logic       i2f_inexact, f2i_inexact, f2i_ovf;
   logic       nan;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         v0 <= 1'b0;
         v1 <= 1'b0;
         v2 <= 1'b0;
      end else begin
         v0 <= issue_valid;
         v1 <= v0;
         v2 <= v1;
      end
   end

   // tags ride along with the valid bit
   always_ff @(posedge clk) begin
      opa0 <= issue_opa;
      op0  <= issue_op;
      op1  <= op0;
      op2  <= op1;
      id0  <= issue_id;
      id1  <= id0;
      id2  <= id1;
   end

   fpu_intfloat_conv_except u_except (
      .clk(clk), .rst(rst), .opa(opa0),
      .inf(cls_inf), .qnan(cls_qnan), .snan(cls_snan), .zero(cls_zero), .denorm(cls_dn)
   );

   fpu_int2float u_i2f (
      .clk(clk), .rst(rst), .opa(opa0), .res(i2f_res), .inexact(i2f_inexact)
   );

   fpu_float2int u_f2i (
      .clk(clk), .rst(rst), .opa(opa0), .res(f2i_res), .inexact(f2i_inexact), .ovf(f2i_ovf)
   );

   assign nan = cls_qnan | cls_snan;

   assign done_valid = v2;
   assign done_id    = id2;

   // infinity already saturates to its own sign inside u_f2i
   always_comb begin
      if (op2 == op_f2i) begin
         done_res   = nan ? word_t'(`FPU_CONV_INT_MAX) : f2i_res;
         done_flags = {nan | cls_inf | f2i_ovf, f2i_inexact | cls_dn,
                       cls_inf, cls_snan, cls_qnan, cls_zero};
      end else begin
         done_res   = i2f_res;
         done_flags = {1'b0, i2f_inexact, 3'b000, i2f_res == '0};
      end
   end

endmodule

`default_nettype wire

// File: hw/fpu_conv_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module fpu_conv_arbiter (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     c0_req,
   input  wire logic                     c1_req,
   input  wire fpu_conv_pkg::conv_op_t   c0_op,
   input  wire fpu_conv_pkg::conv_op_t   c1_op,
   input  wire fpu_conv_pkg::word_t      c0_opa,
   input  wire fpu_conv_pkg::word_t      c1_opa,
   output logic                          c0_ack,
   output logic                          c1_ack,
   output fpu_conv_pkg::word_t           c0_res,
   output fpu_conv_pkg::word_t           c1_res,
   output fpu_conv_pkg::conv_flags_t     c0_flags,
   output fpu_conv_pkg::conv_flags_t     c1_flags,
   output logic                          issue_valid,
   output fpu_conv_pkg::conv_op_t        issue_op,
   output fpu_conv_pkg::word_t           issue_opa,
   output fpu_conv_pkg::client_id_t      issue_id,
   input  wire logic                     done_valid,
   input  wire fpu_conv_pkg::client_id_t done_id,
   input  wire fpu_conv_pkg::word_t      done_res,
   input  wire fpu_conv_pkg::conv_flags_t done_flags
);
   import fpu_conv_pkg::*;

   logic [1:0]    req_v;
   conv_op_t      op_v [2];
   word_t         opa_v [2];
   client_state_t st [2];
   word_t         res_q [2];
   conv_flags_t   flags_q [2];
   logic [1:0]    waiting;
   logic          contested;
   client_id_t    gnt;
   client_id_t    last_gnt;

   assign req_v    = {c1_req, c0_req};
   assign op_v[0]  = c0_op;
   assign op_v[1]  = c1_op;
   assign opa_v[0] = c0_opa;
   assign opa_v[1] = c1_opa;

   assign waiting[0] = (st[0] == cl_wait);
   assign waiting[1] = (st[1] == cl_wait);
   assign contested  = &waiting;
   assign gnt        = contested ? ~last_gnt : client_id_t'(waiting[1]);

   // one issue per cycle straight out of cl_wait
   assign issue_valid = |waiting;
   assign issue_op    = op_v[gnt];
   assign issue_opa   = opa_v[gnt];
   assign issue_id    = gnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         st[0]    <= cl_idle;
         st[1]    <= cl_idle;
         last_gnt <= 1'b1;   // client 0 wins the first tie
      end else begin
         for (int i = 0; i < 2; i++) begin
            case (st[i])
               cl_idle: if (req_v[i]) st[i] <= cl_wait;
               cl_wait: if (gnt == client_id_t'(i)) st[i] <= cl_busy;
               cl_busy: if (done_valid && done_id == client_id_t'(i)) st[i] <= cl_ack;
               cl_ack:  if (!req_v[i]) st[i] <= cl_idle;
               default: st[i] <= cl_idle;
            endcase
         end
         if (contested)
            last_gnt <= gnt;   // only a tie moves priority, so back to back ties alternate
      end
   end

   // result held for the whole ack phase
   always_ff @(posedge clk) begin
      for (int i = 0; i < 2; i++) begin
         if (st[i] == cl_busy && done_valid && done_id == client_id_t'(i)) begin
            res_q[i]   <= done_res;
            flags_q[i] <= done_flags;
         end
      end
   end

   assign c0_ack   = (st[0] == cl_ack);
   assign c1_ack   = (st[1] == cl_ack);
   assign c0_res   = res_q[0];
   assign c1_res   = res_q[1];
   assign c0_flags = flags_q[0];
   assign c1_flags = flags_q[1];

endmodule

`default_nettype wire

// File: hw/fpu_conv_top.sv
`default_nettype none
`timescale 1ns/100ps

module fpu_conv_top (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   c0_req,
   input  wire logic                   c1_req,
   input  wire fpu_conv_pkg::conv_op_t c0_op,
   input  wire fpu_conv_pkg::conv_op_t c1_op,
   input  wire fpu_conv_pkg::word_t    c0_opa,
   input  wire fpu_conv_pkg::word_t    c1_opa,
   output logic                        c0_ack,
   output logic                        c1_ack,
   output fpu_conv_pkg::word_t         c0_res,
   output fpu_conv_pkg::word_t         c1_res,
   output fpu_conv_pkg::conv_flags_t   c0_flags,
   output fpu_conv_pkg::conv_flags_t   c1_flags
);
   import fpu_conv_pkg::*;

   logic        issue_valid;
   conv_op_t    issue_op;
   word_t       issue_opa;
   client_id_t  issue_id;
   logic        done_valid;
   client_id_t  done_id;
   word_t       done_res;
   conv_flags_t done_flags;

   fpu_conv_arbiter u_arb (
      .clk(clk), .rst(rst),
      .c0_req(c0_req), .c1_req(c1_req), .c0_op(c0_op), .c1_op(c1_op),
      .c0_opa(c0_opa), .c1_opa(c1_opa), .c0_ack(c0_ack), .c1_ack(c1_ack),
      .c0_res(c0_res), .c1_res(c1_res), .c0_flags(c0_flags), .c1_flags(c1_flags),
      .issue_valid(issue_valid), .issue_op(issue_op), .issue_opa(issue_opa),
      .issue_id(issue_id), .done_valid(done_valid), .done_id(done_id),
      .done_res(done_res), .done_flags(done_flags)
   );

   fpu_conv_core u_core (
      .clk(clk), .rst(rst),
      .issue_valid(issue_valid), .issue_op(issue_op), .issue_opa(issue_opa),
      .issue_id(issue_id), .done_valid(done_valid), .done_id(done_id),
      .done_res(done_res), .done_flags(done_flags)
   );

endmodule

`default_nettype wire

// File: verification/tb_fpu_conv.sv
`default_nettype none
`timescale 1ns/100ps

module tb_fpu_conv;
   import fpu_conv_pkg::*;

   typedef struct packed {
      client_id_t  client;
      conv_op_t    op;
      word_t       opa;
      word_t       res;
      conv_flags_t flags;
   } vec_t;

   logic        clk;
   logic        rst;
   logic        c0_req;
   logic        c1_req;
   conv_op_t    c0_op;
   conv_op_t    c1_op;
   word_t       c0_opa;
   word_t       c1_opa;
   logic        c0_ack;
   logic        c1_ack;
   word_t       c0_res;
   word_t       c1_res;
   conv_flags_t c0_flags;
   conv_flags_t c1_flags;

   vec_t        vecs [$];
   logic [31:0] lcg_state;
   int          errors;
   int          cycles;
   int          limit;
   int          ack_cycle [2];
   logic [1:0]  prev_ack;
   word_t       prev_res [2];
   conv_flags_t prev_flags [2];

   fpu_conv_top u_dut (
      .clk(clk), .rst(rst),
      .c0_req(c0_req), .c1_req(c1_req), .c0_op(c0_op), .c1_op(c1_op),
      .c0_opa(c0_opa), .c1_opa(c1_opa), .c0_ack(c0_ack), .c1_ack(c1_ack),
      .c0_res(c0_res), .c1_res(c1_res), .c0_flags(c0_flags), .c1_flags(c1_flags)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic ack_of(input int c);
      return c ? c1_ack : c0_ack;
   endfunction

   function automatic logic req_of(input int c);
      return c ? c1_req : c0_req;
   endfunction

   function automatic word_t res_of(input int c);
      return c ? c1_res : c0_res;
   endfunction

   function automatic conv_flags_t flags_of(input int c);
      return c ? c1_flags : c0_flags;
   endfunction

   task automatic drive_port(input int c, input logic req, input conv_op_t op, input word_t opa);
      if (c == 0) begin
         c0_req <= req;
         c0_op  <= op;
         c0_opa <= opa;
      end else begin
         c1_req <= req;
         c1_op  <= op;
         c1_opa <= opa;
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flags(input string name, input conv_flags_t got, input conv_flags_t exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic add_vec(input client_id_t c, input conv_op_t op, input word_t opa,
                          input word_t res, input conv_flags_t flags);
      vec_t v;
      v.client = c;
      v.op     = op;
      v.opa    = opa;
      v.res    = res;
      v.flags  = flags;
      vecs.push_back(v);
   endtask

   // flags are invalid, inexact, inf, snan, qnan, zero
   task automatic load_vectors;
      add_vec(1'b0, op_i2f, 32'h00000000, 32'h00000000, 6'b000001);
      add_vec(1'b1, op_i2f, 32'h00000001, 32'h3f800000, 6'b000000);
      add_vec(1'b0, op_i2f, 32'hffffffff, 32'hbf800000, 6'b000000);
      add_vec(1'b1, op_i2f, 32'h01000000, 32'h4b800000, 6'b000000);
      add_vec(1'b0, op_i2f, 32'h01000001, 32'h4b800000, 6'b010000);   // tie stays even
      add_vec(1'b1, op_i2f, 32'h01000003, 32'h4b800002, 6'b010000);   // tie rounds up to even
      add_vec(1'b0, op_i2f, 32'h7fffffff, 32'h4f000000, 6'b010000);
      add_vec(1'b1, op_i2f, 32'h80000000, 32'hcf000000, 6'b000000);
      add_vec(1'b0, op_f2i, 32'h3fc00000, 32'h00000001, 6'b010000);   // 1.5
      add_vec(1'b1, op_f2i, 32'hc0300000, 32'hfffffffe, 6'b010000);   // -2.75
      add_vec(1'b0, op_f2i, 32'h3e800000, 32'h00000000, 6'b010000);   // 0.25
      add_vec(1'b1, op_f2i, 32'h00000001, 32'h00000000, 6'b010000);   // denormal
      add_vec(1'b0, op_f2i, 32'h00000000, 32'h00000000, 6'b000001);
      add_vec(1'b1, op_f2i, 32'h42f60000, 32'h0000007b, 6'b000000);   // 123.0
      add_vec(1'b0, op_f2i, 32'hc2f60000, 32'hffffff85, 6'b000000);
      add_vec(1'b1, op_f2i, 32'h7f800000, 32'h7fffffff, 6'b101000);
      add_vec(1'b0, op_f2i, 32'hff800000, 32'h80000000, 6'b101000);
      add_vec(1'b1, op_f2i, 32'h7fc00000, 32'h7fffffff, 6'b100010);
      add_vec(1'b0, op_f2i, 32'h7f800001, 32'h7fffffff, 6'b100100);
      add_vec(1'b1, op_f2i, 32'h4f32d05e, 32'h7fffffff, 6'b100000);   // 3.0e9
      add_vec(1'b0, op_f2i, 32'hcf000000, 32'h80000000, 6'b000000);   // -2^31 fits
      add_vec(1'b1, op_f2i, 32'hffc00000, 32'h7fffffff, 6'b100010);   // negative nan saturates high
   endtask

   // one full four-phase transaction on client c
   task automatic do_request(input int c, input vec_t v, input int hold, input int exp_lat);
      int n;
      n = 0;
      @(posedge clk);
      drive_port(c, 1'b1, v.op, v.opa);
      do begin
         @(negedge clk);
         n++;
      end while (!ack_of(c));
      ack_cycle[c] = cycles;
      check_word($sformatf("c%0d_res", c), res_of(c), v.res);
      check_flags($sformatf("c%0d_flags", c), flags_of(c), v.flags);
      if (n - 1 != exp_lat) begin
         errors++;
         $display("CHECK FAILED at %0t: c%0d_ack latency got %0d expected %0d",
                  $time, c, n - 1, exp_lat);
      end
      repeat (hold) @(negedge clk);   // monitor watches the held ack
      @(posedge clk);
      drive_port(c, 1'b0, v.op, v.opa);
      while (ack_of(c))
         @(negedge clk);
   endtask

   // handshake rules checked on every falling edge
   always @(negedge clk) begin
      if (!rst) begin
         for (int c = 0; c < 2; c++) begin
            if (ack_of(c) && !prev_ack[c] && !req_of(c)) begin
               errors++;
               $display("client %0d ack rose while req was low at %0t", c, $time);
            end
            if (!ack_of(c) && prev_ack[c] && req_of(c)) begin
               errors++;
               $display("client %0d ack fell while req was still high at %0t", c, $time);
            end
            if (ack_of(c) && prev_ack[c] &&
                (res_of(c) !== prev_res[c] || flags_of(c) !== prev_flags[c])) begin
               errors++;
               $display("client %0d result changed during ack at %0t", c, $time);
            end
         end
      end
      prev_ack      = {c1_ack, c0_ack};
      prev_res[0]   = c0_res;
      prev_res[1]   = c1_res;
      prev_flags[0] = c0_flags;
      prev_flags[1] = c1_flags;
   end

   initial begin
      cycles = 0;
      wait (limit > 0);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout, run did not finish within %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      vec_t        v;
      vec_t        pv;
      logic [31:0] r;
      logic        partner;
      int          hold;
      int          phold;
      int          win;
      int          ties;
      int          errs_before;
      rst       = 1'b1;
      c0_req    = 1'b0;
      c1_req    = 1'b0;
      c0_op     = op_i2f;
      c1_op     = op_i2f;
      c0_opa    = '0;
      c1_opa    = '0;
      errors    = 0;
      ties      = 0;
      win       = 0;   // client 0 takes the first tie
      lcg_state = 32'h4a113cf0;
      load_vectors();
      limit = 30 * vecs.size() + 5;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < vecs.size(); i++) begin
         v  = vecs[i];
         pv = vecs[(i + 1) % vecs.size()];
         lcg_state = lcg_next(lcg_state);
         r       = lcg_state;
         partner = (i < 2) || r[20];   // first two rounds always contend
         hold    = r[18:16];
         phold   = r[26:24];
         errs_before = errors;
         if (partner) begin
            fork
               do_request(v.client, v, hold, (v.client == win) ? 5 : 6);
               do_request(1 - v.client, pv, phold, (v.client == win) ? 6 : 5);
            join
            if (ack_cycle[win] >= ack_cycle[1 - win]) begin
               errors++;
               $display("tie winner client %0d did not ack first", win);
            end
            ties++;
            win = 1 - win;
         end else begin
            do_request(v.client, v, hold, 5);
         end
         $display("test %0d c%0d %s opa %h res %h flags %b%s %s", i, v.client,
                  (v.op == op_f2i) ? "f2i" : "i2f", v.opa, v.res, v.flags,
                  partner ? " contended" : "", (errors == errs_before) ? "ok" : "fail");
      end
      $display("tests %0d, contention rounds %0d, errors %0d", vecs.size(), ties, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hw/fpu_conv_pkg.sv
hw/fpu_intfloat_conv_except.sv
hw/fpu_int2float.sv
hw/fpu_float2int.sv
hw/fpu_conv_core.sv
hw/fpu_conv_arbiter.sv
hw/fpu_conv_top.sv
verification/tb_fpu_conv.sv

// File: Bender.yml
package:
  name: fpu_conv

export_include_dirs:
  - include

sources:
  - hw/fpu_conv_pkg.sv
  - hw/fpu_intfloat_conv_except.sv
  - hw/fpu_int2float.sv
  - hw/fpu_float2int.sv
  - hw/fpu_conv_core.sv
  - hw/fpu_conv_arbiter.sv
  - hw/fpu_conv_top.sv
  - target: simulation
    files:
      - verification/tb_fpu_conv.sv
